/* hw/botPkg.sv */
package botPkg;

    // a bot holds one function value per input assignment of numVars variables.
    localparam int numVars = 7;
    localparam int botWidth = 1 << numVars;

    // two swaps pick the variables that land in positions 0 and 1.
    localparam int seriesLength = numVars * (numVars - 1);

    typedef logic [botWidth-1:0] botT;

    // index of the variable swapped with variable 0, from 0 to 6.
    typedef logic [2:0] state7T;

    // index of the variable swapped with variable 1, minus one, from 0 to 5.
    typedef logic [2:0] state6T;

    localparam state7T lastState7 = state7T'(numVars - 1);
    localparam state6T lastState6 = state6T'(numVars - 2);

    // counts the variants seen so far in one series.
    localparam int seriesCountWidth = $clog2(seriesLength);

    typedef logic [seriesCountWidth-1:0] seriesCountT;

    localparam seriesCountT lastSeriesCount = seriesCountT'(seriesLength - 1);

endpackage

/* hw/varSwapNetwork.sv */
`timescale 1ns/100ps

module varSwapNetwork
    import botPkg::*;
#(
    parameter int varA = 0,
    parameter int varB = 0
) (
    input  botT bot,
    output botT swapped
);

    // output bit k reads the input bit whose index has bits varA and varB exchanged.
    function automatic int swapIndex(input int idx);
        logic [numVars-1:0] src;
        src = idx[numVars-1:0];
        src[varA] = idx[varB];
        src[varB] = idx[varA];
        return int'(src);
    endfunction

    if (varA < 0 || varA >= numVars || varB < 0 || varB >= numVars) begin : gBadVar
        $error("varSwapNetwork: swap variable out of range");
    end

    for (genvar i = 0; i < botWidth; i++) begin : gBit
        assign swapped[i] = bot[swapIndex(i)]; // equal variables give plain wiring.
    end

endmodule

/* hw/permutationGenerator67.sv */
`timescale 1ns/100ps

module permutationGenerator67
    import botPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  botT  inBot,
    input  logic inWrite,
    output logic inputReady,
    output botT  permBot,
    output logic permValid,
    output logic seriesDone
);

    botT        nextBot;
    logic       nextBotValid;
    state7T     permutState7;
    state6T     permutState6;
    state6T     permutState6D;
    botT        workBot;
    logic       workValid;
    logic       endOfPermutation;
    botT        firstStageWires [numVars];
    botT        secondStageWires [numVars - 1];
    botT        stage1Bot;
    botT        stage2Bot;
    logic [1:0] validPipe;
    logic [1:0] donePipe;

    assign inputReady = !nextBotValid; // the buffer holds a single bot.
    assign endOfPermutation = (permutState7 == lastState7) && (permutState6 == lastState6);

    // the counters run whether or not a bot is loaded, with s6 counting fastest.
    always_ff @(posedge clk) begin
        if (rst) begin
            permutState7 <= '0;
            permutState6 <= '0;
        end else if (permutState6 == lastState6) begin
            permutState6 <= '0;
            permutState7 <= (permutState7 == lastState7) ? '0 : permutState7 + 1'b1;
        end else begin
            permutState6 <= permutState6 + 1'b1;
        end
    end

    // The buffered bot only moves into permutation when a full series of states has passed,
    // so a new bot may wait up to one series before it starts.
    always_ff @(posedge clk) begin
        if (rst) begin
            nextBotValid <= 1'b0;
            workValid <= 1'b0;
        end else begin
            if (endOfPermutation) begin
                workValid <= nextBotValid;
            end
            if (inWrite) begin
                nextBotValid <= 1'b1;
            end else if (endOfPermutation) begin
                nextBotValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (endOfPermutation) begin
            workBot <= nextBot;
        end
        if (inWrite) begin
            nextBot <= inBot; // a write in the hand-over cycle lands behind the moving bot.
        end
    end

    for (genvar k = 0; k < numVars; k++) begin : gFirstSwap
        varSwapNetwork #(
            .varA(0),
            .varB(k)
        ) u_swap (
            .bot(workBot),
            .swapped(firstStageWires[k])
        );
    end

    // the second swap works on the already swapped variant, so positions 1..6 are renamed.
    for (genvar k = 0; k < numVars - 1; k++) begin : gSecondSwap
        varSwapNetwork #(
            .varA(1),
            .varB(k + 1)
        ) u_swap (
            .bot(stage1Bot),
            .swapped(secondStageWires[k])
        );
    end

    always_ff @(posedge clk) begin
        stage1Bot <= firstStageWires[permutState7];
        stage2Bot <= secondStageWires[permutState6D];
    end

    // valid and end of series follow the same two stages as the data.
    always_ff @(posedge clk) begin
        if (rst) begin
            permutState6D <= '0;
            validPipe <= '0;
            donePipe <= '0;
        end else begin
            permutState6D <= permutState6;
            validPipe <= {validPipe[0], workValid};
            donePipe <= {donePipe[0], workValid && endOfPermutation};
        end
    end

    assign permBot = stage2Bot;
    assign permValid = validPipe[1];
    assign seriesDone = donePipe[1];

    // A write into a full buffer would drop a bot that was never permuted.
    assert property (@(posedge clk) disable iff (rst) inWrite |-> inputReady)
        else $error("permutationGenerator67: inWrite while inputReady is low");

endmodule

/* hw/minimumReducer.sv */
`timescale 1ns/100ps

module minimumReducer
    import botPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  botT  permBot,
    input  logic permValid,
    input  logic seriesDone,
    output botT  minBot,
    output logic minValid
);

    botT         runMin;
    botT         nextMin;
    logic        firstOfSeries;
    seriesCountT seriesCount;

    // the first variant replaces whatever the previous series left behind.
    assign nextMin = (firstOfSeries || permBot < runMin) ? permBot : runMin;

    always_ff @(posedge clk) begin
        if (rst) begin
            firstOfSeries <= 1'b1;
            minValid <= 1'b0;
            seriesCount <= '0;
        end else begin
            minValid <= permValid && seriesDone; // one strobe per series, no back-pressure.
            if (permValid) begin
                firstOfSeries <= seriesDone;
                seriesCount <= seriesDone ? '0 : seriesCount + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (permValid) begin
            runMin <= nextMin;
        end
        if (permValid && seriesDone) begin
            minBot <= nextMin; // held until the next series ends.
        end
    end

    assert property (@(posedge clk) disable iff (rst) seriesDone |-> permValid)
        else $error("minimumReducer: seriesDone without permValid");

    // The generator must deliver every double swap before it closes a series.
    assert property (@(posedge clk) disable iff (rst)
        permValid && seriesDone |-> seriesCount == lastSeriesCount)
        else $error("minimumReducer: series closed after %0d variants", seriesCount + 1);

endmodule

/* hw/botCanonicalizer.sv */
`timescale 1ns/100ps

module botCanonicalizer
    import botPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  botT  inBot,
    input  logic inWrite,
    output logic inputReady,
    output botT  minBot,
    output logic minValid
);

    botT  permBot;
    logic permValid;
    logic seriesDone;

    // one series of variants per accepted bot.
    permutationGenerator67 u_permutationGenerator67 (
        .clk(clk),
        .rst(rst),
        .inBot(inBot),
        .inWrite(inWrite),
        .inputReady(inputReady),
        .permBot(permBot),
        .permValid(permValid),
        .seriesDone(seriesDone)
    );

    // reduces each series to its smallest variant.
    minimumReducer u_minimumReducer (
        .clk(clk),
        .rst(rst),
        .permBot(permBot),
        .permValid(permValid),
        .seriesDone(seriesDone),
        .minBot(minBot),
        .minValid(minValid)
    );

endmodule

/* test/botRefPkg.sv */
package botRefPkg;

    import botPkg::*;

    // exchanges input variables varA and varB of a truth table.
    function automatic botT swapVars(input botT bot, input int varA, input int varB);
        botT result;
        int  bitA;
        int  bitB;
        int  src;
        for (int k = 0; k < botWidth; k++) begin
            bitA = (k >> varA) & 1;
            bitB = (k >> varB) & 1;
            src = k;
            if (bitA != bitB) begin
                src = k ^ ((1 << varA) | (1 << varB)); // flipping both bits swaps them.
            end
            result[k] = bot[src];
        end
        return result;
    endfunction

    // Smallest of the 42 variants: variable 0 swapped with s7, then
    // variable 1 swapped with s6 + 1 on that result.
    function automatic botT referenceMinimum(input botT bot);
        botT best;
        botT firstSwap;
        botT variant;
        best = bot; // s7 = 0 and s6 = 0 give the bot itself.
        for (int s7 = 0; s7 < numVars; s7++) begin
            firstSwap = swapVars(bot, 0, s7);
            for (int s6 = 0; s6 < numVars - 1; s6++) begin
                variant = swapVars(firstSwap, 1, s6 + 1);
                if (variant < best) begin
                    best = variant;
                end
            end
        end
        return best;
    endfunction

endpackage

/* test/tbBotCanonicalizer.sv */
`timescale 1ns/100ps

module tbBotCanonicalizer
    import botPkg::*, botRefPkg::*;
();

    localparam int numEntries = 16;
    localparam int numFixed = 5;
    localparam int cycleLimit = numEntries * 100 + 200;

    logic clk = 1'b0;
    logic rst;
    botT  inBot;
    logic inWrite;
    logic inputReady;
    botT  minBot;
    logic minValid;

    botT botTable [numEntries];
    botT expTable [numEntries];
    int  gapTable [numEntries] = '{0, 0, 3, 0, 1, 0, 0, 7, 0, 2, 0, 0, 12, 0, 5, 0};

    int          pending [$]; // entry indices in write order.
    int          errorCount = 0;
    int          strobeCount = 0;
    int          cycleCount = 0;
    int          doneIdx;

    botCanonicalizer u_botCanonicalizer (
        .clk(clk),
        .rst(rst),
        .inBot(inBot),
        .inWrite(inWrite),
        .inputReady(inputReady),
        .minBot(minBot),
        .minValid(minValid)
    );

    always #10 clk = ~clk;

    task automatic checkValue(input string name, input botT actual, input botT expected);
        if (actual !== expected) begin
            errorCount++;
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    // waits for buffer space, then strobes inWrite for one cycle.
    task automatic applyEntry(input int idx);
        @(posedge clk);
        while (!inputReady) begin
            @(posedge clk);
        end
        inBot <= botTable[idx];
        inWrite <= 1'b1;
        pending.push_back(idx);
        @(posedge clk);
        inWrite <= 1'b0;
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            if (inWrite && !inputReady) begin
                errorCount++;
                $display("protocol error at %0t: inWrite was high while inputReady was low",
                    $time);
            end
            if (minValid) begin
                strobeCount++;
                if (pending.size() == 0) begin
                    errorCount++;
                    $display("unexpected minValid at %0t with no bot waiting for a result",
                        $time);
                end else begin
                    doneIdx = pending.pop_front();
                    checkValue("minBot", minBot, expTable[doneIdx]);
                    if (minBot > botTable[doneIdx]) begin
                        errorCount++;
                        $display("minBot at %0t is greater than the bot that was written", $time);
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("timeout after %0d cycles with %0d of %0d results seen",
                cycleCount, strobeCount, numEntries);
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        rst = 1'b1;
        inWrite = 1'b0;
        inBot = '0;
        void'($urandom(32'hb352));

        botTable[0] = '0;
        botTable[1] = '1;
        botTable[2] = botT'(1) << (botWidth - 1); // index 127 has every variable set.
        botTable[3] = botT'(1) << 1;
        botTable[4] = {{(botWidth / 2){1'b1}}, {(botWidth / 2){1'b0}}}; // the function x6.
        for (int i = numFixed; i < numEntries; i++) begin
            botTable[i] = {$urandom(), $urandom(), $urandom(), $urandom()};
        end
        for (int i = 0; i < numEntries; i++) begin
            expTable[i] = referenceMinimum(botTable[i]);
        end

        @(posedge clk);
        for (int i = 1; i < 3; i++) begin
            @(posedge clk);
            checkValue("minValid", botT'(minValid), botT'(1'b0));
            checkValue("inputReady", botT'(inputReady), botT'(1'b1));
        end
        rst <= 1'b0;
        @(posedge clk);
        checkValue("minValid", botT'(minValid), botT'(1'b0));
        checkValue("inputReady", botT'(inputReady), botT'(1'b1));

        for (int i = 0; i < numEntries; i++) begin
            applyEntry(i);
            repeat (gapTable[i]) @(posedge clk);
        end

        while (strobeCount < numEntries) begin
            @(posedge clk);
        end
        repeat (2 * seriesLength) @(posedge clk); // any extra strobe would show up here.

        checkValue("strobeCount", botT'(strobeCount), botT'(numEntries));
        if (pending.size() != 0) begin
            errorCount++;
            $display("%0d written bots never produced a result", pending.size());
        end

        $display("errors: %0d, results: %0d of %0d", errorCount, strobeCount, numEntries);
        if (errorCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* files.f */
hw/botPkg.sv
hw/varSwapNetwork.sv
hw/permutationGenerator67.sv
hw/minimumReducer.sv
hw/botCanonicalizer.sv
test/botRefPkg.sv
test/tbBotCanonicalizer.sv

/* run.sh */
#!/bin/sh
# Builds the bot canonicalizer testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
simName=simBotCanonicalizer
logFile=sim.log

verilator --binary --timing --assert \
    -f files.f \
    --top-module tbBotCanonicalizer \
    -Mdir "$buildDir" \
    -o "$simName"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$buildDir/$simName" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -q "tests failed" "$logFile"; then
    exit 1
fi

exit 0
